// File: fpuAddSub.f
logic/fpuFormatPkg.sv
logic/fpuBusPkg.sv
logic/fpuLZC.sv
logic/fpuNormalizer.sv
logic/fpuAddSub.sv
logic/fpuCmdQueue.sv
logic/fpuAxilFront.sv
logic/fpuAddSubTop.sv
verification/fpuAddSubChecker.sv
verification/fpuAddSubTb.sv

// File: logic/fpuAddSub.sv
`timescale 1ns/10ps

module fpuAddSub #(
  parameter int LZCW = 20
) (
  input  logic                  clk,
  input  logic                  rstN,
  input  fpuBusPkg::fpuCmd_t    head,
  input  logic                  notEmpty,
  output logic                  pop,
  input  logic                  resultTaken,
  output fpuBusPkg::fpuResult_t result
);

  localparam int FRACW = fpuFormatPkg::FRACW;
  localparam int EXPW = fpuFormatPkg::EXPW;
  // Extended significand and sum widths.
  localparam int SIGW = LZCW + 1;
  localparam int SUMW = LZCW + 3;
  localparam int CNTW = $clog2(LZCW + 1);

  fpuFormatPkg::fp16_t a, b, largeNum, smallNum, normOut;
  logic effS1, effS2, swap, signLarge, effSub;
  logic aNaN, bNaN, aInf, bInf;
  logic [EXPW-1:0] expLarge, expSmall, alignShift;
  logic [FRACW:0] sigLarge, sigSmall;
  logic [2*SIGW-1:0] alignWide;
  logic alignSticky;
  logic [SUMW-1:0] extLarge, extSmall, sumWide;
  logic [CNTW-1:0] lzCount;
  fpuFormatPkg::opStatusFlag_t normFlags, nextFlags, flagsQ;
  fpuFormatPkg::condCode_t nextCodes, codesQ;
  fpuFormatPkg::fpWord_u nextValue, valueQ;
  logic resultValid;

  assign a = head.in1.fields;
  assign b = head.in2.fields;

  // Subtract flips the sign of in2.
  assign effS1 = a.sign;
  assign effS2 = b.sign ^ head.sub;
  assign effSub = effS1 ^ effS2;

  // Sort by magnitude, larger one on top.
  assign swap = {b.exp, b.frac} > {a.exp, a.frac};
  assign largeNum = swap ? b : a;
  assign smallNum = swap ? a : b;
  assign signLarge = swap ? effS2 : effS1;

  // Subnormals use exponent 1 and no hidden bit.
  assign expLarge = (largeNum.exp == '0) ? EXPW'(1) : largeNum.exp;
  assign expSmall = (smallNum.exp == '0) ? EXPW'(1) : smallNum.exp;
  assign sigLarge = {largeNum.exp != '0, largeNum.frac};
  assign sigSmall = {smallNum.exp != '0, smallNum.frac};

  // Align. The low half catches every bit shifted out.
  assign alignShift = expLarge - expSmall;
  assign alignWide = {sigSmall, {(LZCW-FRACW){1'b0}}, {SIGW{1'b0}}} >> alignShift;
  assign alignSticky = |alignWide[SIGW-1:0];

  // Sticky rides as an extra LSB so a borrow rounds correctly.
  assign extLarge = {1'b0, sigLarge, {(LZCW-FRACW){1'b0}}, 1'b0};
  assign extSmall = {1'b0, alignWide[2*SIGW-1:SIGW], alignSticky};
  assign sumWide = effSub ? extLarge - extSmall : extLarge + extSmall;

  fpuLZC #(.WIDTH(LZCW)) lzc0 (
    .lzcIn  (sumWide[SUMW-3:1]),
    .lzcOut (lzCount)
  );

  fpuNormalizer norm0 (
    .unnormSign    (signLarge),
    .unnormInt     (sumWide[SUMW-1:SUMW-2]),
    .unnormFrac    (sumWide[SUMW-3:1]),
    .unnormExp     (expLarge),
    .lzCount       (lzCount),
    .sticky        (sumWide[0]),
    .normOut       (normOut),
    .opStatusFlags (normFlags)
  );

  assign aNaN = (a.exp == '1) && (a.frac != '0);
  assign bNaN = (b.exp == '1) && (b.frac != '0);
  assign aInf = (a.exp == '1) && (a.frac == '0);
  assign bInf = (b.exp == '1) && (b.frac == '0);

  // Special values bypass the normalizer.
  always_comb begin
    nextFlags = '0;
    nextValue.fields = normOut;
    if (aNaN || bNaN) begin
      nextValue.bits = fpuFormatPkg::QNAN;
    end else if (aInf && bInf && effSub) begin
      nextValue.bits = fpuFormatPkg::QNAN;
      nextFlags.invalid = 1'b1;
    end else if (aInf) begin
      nextValue.fields = '{sign: effS1, exp: '1, frac: '0};
    end else if (bInf) begin
      nextValue.fields = '{sign: effS2, exp: '1, frac: '0};
    end else if (sumWide == '0) begin
      // Exact cancellation is +0.
      nextValue.bits = '0;
    end else begin
      nextFlags = normFlags;
    end

    nextCodes.Z = (nextValue.bits == '0);
    nextCodes.C = 1'b0;
    nextCodes.N = nextValue.fields.sign;
    nextCodes.V = 1'b0;
  end

  // Take the head only when the result register is free.
  assign pop = notEmpty && !resultValid;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resultValid <= 1'b0;
    end else if (pop) begin
      resultValid <= 1'b1;
    end else if (resultTaken) begin
      resultValid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      flagsQ <= nextFlags;
      codesQ <= nextCodes;
      valueQ <= nextValue;
    end
  end

  assign result = '{valid: resultValid, flags: flagsQ, codes: codesQ, value: valueQ};

  // A waiting head must not change under later pushes.
  assert property (@(posedge clk) disable iff (!rstN) notEmpty && !pop |=> $stable(head));

  // The front end only takes a result that is held.
  assert property (@(posedge clk) disable iff (!rstN) resultTaken |-> resultValid);

endmodule

// File: logic/fpuAddSubTop.sv
`timescale 1ns/10ps

module fpuAddSubTop #(
  parameter int CMD_DEPTH = 4
) (
  input  logic                clk,
  input  logic                rstN,
  input  fpuBusPkg::axilReq_t bus,
  output fpuBusPkg::axilRsp_t busRsp
);

  // Front end to queue.
  logic                             pushValid;
  fpuBusPkg::fpuCmd_t               pushCmd;
  logic                             full;
  logic [$clog2(CMD_DEPTH+1)-1:0]   count;

  // Queue to arithmetic block.
  fpuBusPkg::fpuCmd_t               head;
  logic                             notEmpty;
  logic                             pop;

  // Result path back to the bus.
  fpuBusPkg::fpuResult_t            result;
  logic                             resultTaken;

  fpuAxilFront #(.DEPTH(CMD_DEPTH)) front0 (
    .clk         (clk),
    .rstN        (rstN),
    .bus         (bus),
    .busRsp      (busRsp),
    .pushValid   (pushValid),
    .pushCmd     (pushCmd),
    .full        (full),
    .result      (result),
    .resultTaken (resultTaken),
    .count       (count)
  );

  fpuCmdQueue #(.DEPTH(CMD_DEPTH)) queue0 (
    .clk       (clk),
    .rstN      (rstN),
    .pushValid (pushValid),
    .pushCmd   (pushCmd),
    .full      (full),
    .head      (head),
    .notEmpty  (notEmpty),
    .pop       (pop),
    .count     (count)
  );

  // Sum width covers the fraction plus as many guard bits.
  fpuAddSub #(.LZCW(2 * fpuFormatPkg::FRACW)) addSub0 (
    .clk         (clk),
    .rstN        (rstN),
    .head        (head),
    .notEmpty    (notEmpty),
    .pop         (pop),
    .resultTaken (resultTaken),
    .result      (result)
  );

endmodule

// File: logic/fpuAxilFront.sv
`timescale 1ns/10ps

module fpuAxilFront #(
  parameter int DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       rstN,
  input  fpuBusPkg::axilReq_t        bus,
  output fpuBusPkg::axilRsp_t        busRsp,
  output logic                       pushValid,
  output fpuBusPkg::fpuCmd_t         pushCmd,
  input  logic                       full,
  input  fpuBusPkg::fpuResult_t      result,
  output logic                       resultTaken,
  input  logic [$clog2(DEPTH+1)-1:0] count
);

  localparam int DATAW = fpuBusPkg::DATAW;

  // Operand register, one write loads both operands.
  fpuFormatPkg::fpWord_u opIn1;
  fpuFormatPkg::fpWord_u opIn2;

  logic             wrAccept;
  logic             rdAccept;
  logic             cmdWrite;
  logic             bvalidQ;
  logic             rvalidQ;
  logic [1:0]       brespQ;
  logic [1:0]       brespNext;
  logic [1:0]       rrespQ;
  logic [1:0]       rrespNext;
  logic [DATAW-1:0] rdataQ;
  logic [DATAW-1:0] rdataNext;

  // AW and W are taken together, one write at a time.
  assign wrAccept = bus.awvalid && bus.wvalid && !bvalidQ;
  assign rdAccept = bus.arvalid && !rvalidQ;

  // A CMD write pushes in its accept cycle unless the queue is full.
  assign cmdWrite = wrAccept && (bus.awaddr == fpuBusPkg::ADDR_CMD);
  assign pushValid = cmdWrite && !full;
  assign pushCmd = '{sub: bus.wdata[fpuBusPkg::CMD_SUB_BIT], in1: opIn1, in2: opIn2};

  // Write response by address.
  always_comb begin
    case (bus.awaddr)
      fpuBusPkg::ADDR_OPERANDS: brespNext = fpuBusPkg::RESP_OKAY;
      fpuBusPkg::ADDR_CMD: brespNext = full ? fpuBusPkg::RESP_SLVERR : fpuBusPkg::RESP_OKAY;
      default: brespNext = fpuBusPkg::RESP_SLVERR;
    endcase
  end

  // Read data by address, zero-extended.
  always_comb begin
    rdataNext = '0;
    rrespNext = fpuBusPkg::RESP_OKAY;
    case (bus.araddr)
      fpuBusPkg::ADDR_OPERANDS: rdataNext = {opIn2.bits, opIn1.bits};
      fpuBusPkg::ADDR_RESULT: rdataNext = DATAW'(result);
      fpuBusPkg::ADDR_STATUS: rdataNext = DATAW'(count);
      default: rrespNext = fpuBusPkg::RESP_SLVERR;
    endcase
  end

  // Reading a held result frees the result register.
  assign resultTaken = rdAccept && (bus.araddr == fpuBusPkg::ADDR_RESULT) && result.valid;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      bvalidQ <= 1'b0;
      rvalidQ <= 1'b0;
    end else begin
      if (wrAccept) begin
        bvalidQ <= 1'b1;
      end else if (bus.bready) begin
        bvalidQ <= 1'b0;
      end
      if (rdAccept) begin
        rvalidQ <= 1'b1;
      end else if (bus.rready) begin
        rvalidQ <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wrAccept) begin
      brespQ <= brespNext;
    end
    if (wrAccept && (bus.awaddr == fpuBusPkg::ADDR_OPERANDS)) begin
      // Low half is in1, high half is in2.
      opIn1.bits <= bus.wdata[15:0];
      opIn2.bits <= bus.wdata[31:16];
    end
    if (rdAccept) begin
      rdataQ <= rdataNext;
      rrespQ <= rrespNext;
    end
  end

  assign busRsp = '{
    awready: wrAccept,
    wready:  wrAccept,
    bvalid:  bvalidQ,
    bresp:   brespQ,
    arready: rdAccept,
    rvalid:  rvalidQ,
    rdata:   rdataQ,
    rresp:   rrespQ
  };

  // Responses hold, unchanged, until the host is ready.
  assert property (@(posedge clk) disable iff (!rstN)
    bvalidQ && !bus.bready |=> bvalidQ && $stable(brespQ));

  assert property (@(posedge clk) disable iff (!rstN)
    rvalidQ && !bus.rready |=> rvalidQ && $stable(rdataQ) && $stable(rrespQ));

endmodule

// File: logic/fpuBusPkg.sv
package fpuBusPkg;

  // AXI4-Lite address and data widths.
  parameter int ADDRW = 4;
  parameter int DATAW = 32;

  // Master-driven AXI4-Lite signals.
  typedef struct packed {
    logic             awvalid;
    logic [ADDRW-1:0] awaddr;
    logic             wvalid;
    logic [DATAW-1:0] wdata;
    logic             bready;
    logic             arvalid;
    logic [ADDRW-1:0] araddr;
    logic             rready;
  } axilReq_t;

  // Slave-driven AXI4-Lite signals.
  typedef struct packed {
    logic             awready;
    logic             wready;
    logic             bvalid;
    logic [1:0]       bresp;
    logic             arready;
    logic             rvalid;
    logic [DATAW-1:0] rdata;
    logic [1:0]       rresp;
  } axilRsp_t;

  // Queued command.
  // The operands are copied from the operand register at the CMD write.
  typedef struct packed {
    logic                  sub;
    fpuFormatPkg::fpWord_u in1;
    fpuFormatPkg::fpWord_u in2;
  } fpuCmd_t;

  // Result register, valid lands on bit 24 of the RESULT read data.
  typedef struct packed {
    logic                        valid;
    fpuFormatPkg::opStatusFlag_t flags;
    fpuFormatPkg::condCode_t     codes;
    fpuFormatPkg::fpWord_u       value;
  } fpuResult_t;

  // Register map.
  parameter logic [ADDRW-1:0] ADDR_OPERANDS = 4'h0;
  parameter logic [ADDRW-1:0] ADDR_CMD = 4'h4;
  parameter logic [ADDRW-1:0] ADDR_RESULT = 4'h8;
  parameter logic [ADDRW-1:0] ADDR_STATUS = 4'hC;

  // Bit of the CMD word that selects subtract.
  parameter int CMD_SUB_BIT = 0;

  // Response codes.
  parameter logic [1:0] RESP_OKAY = 2'b00;
  parameter logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: logic/fpuCmdQueue.sv
`timescale 1ns/10ps

module fpuCmdQueue #(
  parameter int DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       pushValid,
  input  fpuBusPkg::fpuCmd_t         pushCmd,
  output logic                       full,
  output fpuBusPkg::fpuCmd_t         head,
  output logic                       notEmpty,
  input  logic                       pop,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  localparam int PTRW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNTW = $clog2(DEPTH + 1);

  fpuBusPkg::fpuCmd_t mem [DEPTH];
  logic [PTRW-1:0] rdPtr;
  logic [PTRW-1:0] wrPtr;

  // Wraps at DEPTH, which need not be a power of two.
  function automatic logic [PTRW-1:0] nextPtr(input logic [PTRW-1:0] ptr);
    return (ptr == PTRW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (pushValid) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (pop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      case ({pushValid, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pushValid) begin
      mem[wrPtr] <= pushCmd;
    end
  end

  assign head = mem[rdPtr];
  assign full = (count == CNTW'(DEPTH));
  assign notEmpty = (count != '0);

  // The front end checks full before it pushes.
  assert property (@(posedge clk) disable iff (!rstN) pushValid |-> !full);

  // The arithmetic block only pops a present head.
  assert property (@(posedge clk) disable iff (!rstN) pop |-> notEmpty);

endmodule

// File: logic/fpuFormatPkg.sv
package fpuFormatPkg;

  // Field widths of the half-precision format.
  parameter int EXPW = 5;
  parameter int FRACW = 10;

  // Exponent bias.
  parameter int BIAS = 15;

  // Largest exponent of a finite number.
  parameter int EXP_MAX = 30;

  // Canonical quiet NaN.
  parameter logic [15:0] QNAN = 16'h7E00;

  // Sign, biased exponent and fraction.
  typedef struct packed {
    logic             sign;
    logic [EXPW-1:0]  exp;
    logic [FRACW-1:0] frac;
  } fp16_t;

  // One FP16 word, seen as fields or as the raw bits on the bus.
  typedef union packed {
    fp16_t       fields;
    logic [15:0] bits;
  } fpWord_u;

  // Condition codes.
  // C and V stay at zero for add and subtract.
  typedef struct packed {
    logic Z;
    logic C;
    logic N;
    logic V;
  } condCode_t;

  // IEEE status flags raised by one operation.
  typedef struct packed {
    logic invalid;
    logic overflow;
    logic underflow;
    logic inexact;
  } opStatusFlag_t;

endpackage

// File: logic/fpuLZC.sv
`timescale 1ns/10ps

module fpuLZC #(
  parameter int WIDTH = 20
) (
  input  logic [WIDTH-1:0]              lzcIn,
  output logic [$clog2(WIDTH+1)-1:0]    lzcOut
);

  localparam int CNTW = $clog2(WIDTH + 1);

  // Priority scan from the LSB up.
  // The last set bit seen is the most significant one.
  always_comb begin
    // All zero counts as the full width.
    lzcOut = CNTW'(WIDTH);
    for (int i = 0; i < WIDTH; i++) begin
      if (lzcIn[i]) begin
        lzcOut = CNTW'(WIDTH - 1 - i);
      end
    end
  end

endmodule

// File: logic/fpuNormalizer.sv
`timescale 1ns/10ps

module fpuNormalizer (
  input  logic                               unnormSign,
  input  logic [1:0]                         unnormInt,
  input  logic [2*fpuFormatPkg::FRACW-1:0]   unnormFrac,
  input  logic [fpuFormatPkg::EXPW-1:0]      unnormExp,
  input  logic [fpuFormatPkg::EXPW-1:0]      lzCount,
  input  logic                               sticky,
  output fpuFormatPkg::fp16_t                normOut,
  output fpuFormatPkg::opStatusFlag_t        opStatusFlags
);

  localparam int FRACW = fpuFormatPkg::FRACW;
  localparam int EW = fpuFormatPkg::EXPW;
  localparam int FW = 2 * FRACW;

  // Integer part and fraction as one word, hidden bit at FW after the shift.
  logic [FW+1:0] shiftIn;
  logic [FW+1:0] shifted;
  logic [EW:0]   leftMax;
  logic [EW:0]   leftAmt;
  logic [EW:0]   expAdj;
  logic          stickyAdj;

  logic            guard;
  logic            roundBit;
  logic            stickyAll;
  logic            roundUp;
  logic [FRACW+1:0] mantRnd;
  logic [EW:0]     expRnd;
  logic            tiny;
  logic            inexact;
  logic            overflow;

  assign shiftIn = {unnormInt, unnormFrac};

  always_comb begin
    // Left shift puts the leading one on the hidden bit.
    // It stops at exponent 1, which leaves a subnormal.
    leftMax = {1'b0, unnormExp} - 1'b1;
    leftAmt = {1'b0, lzCount} + 1'b1;
    if (leftAmt > leftMax) begin
      leftAmt = leftMax;
    end

    if (unnormInt[1]) begin
      // Carry out of the integer part.
      shifted = shiftIn >> 1;
      stickyAdj = sticky | unnormFrac[0];
      expAdj = {1'b0, unnormExp} + 1'b1;
    end else if (unnormInt[0]) begin
      // Already normalized.
      shifted = shiftIn;
      stickyAdj = sticky;
      expAdj = {1'b0, unnormExp};
    end else begin
      shifted = shiftIn << leftAmt;
      stickyAdj = sticky;
      expAdj = {1'b0, unnormExp} - leftAmt;
    end
  end

  // Guard and round sit just below the kept fraction.
  assign guard = shifted[FRACW-1];
  assign roundBit = shifted[FRACW-2];
  assign stickyAll = stickyAdj | (|shifted[FRACW-3:0]);

  // Nearest-even, ties go to the even LSB.
  assign roundUp = guard & (roundBit | stickyAll | shifted[FRACW]);
  assign mantRnd = {1'b0, shifted[FW:FRACW]} + (FRACW + 2)'(roundUp);

  // A mantissa carry bumps the exponent, the fraction is then zero.
  assign expRnd = mantRnd[FRACW+1] ? expAdj + 1'b1 : expAdj;

  assign overflow = expRnd > (EW + 1)'(fpuFormatPkg::EXP_MAX);
  assign inexact = guard | roundBit | stickyAll | overflow;

  // tiny before rounding.
  assign tiny = ~shifted[FW];

  always_comb begin
    normOut.sign = unnormSign;
    if (overflow) begin
      // Round to nearest overflows to infinity.
      normOut.exp = '1;
      normOut.frac = '0;
    end else begin
      // No hidden bit after rounding means exponent field 0.
      normOut.exp = (mantRnd[FRACW+1:FRACW] != 2'b00) ? expRnd[EW-1:0] : '0;
      normOut.frac = mantRnd[FRACW-1:0];
    end

    opStatusFlags.invalid = 1'b0;
    opStatusFlags.overflow = overflow;
    opStatusFlags.underflow = tiny & inexact;
    opStatusFlags.inexact = inexact;
  end

endmodule

// File: runSim.sh
#!/usr/bin/env bash
# Builds the testbench and DUT with Verilator, runs the simulation and looks for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -sv --top-module fpuAddSubTb -f fpuAddSub.f \
  -Mdir obj_dir -o fpuAddSubSim || { echo "Verilator build failed"; exit 1; }
simOut="$(./obj_dir/fpuAddSubSim)"
echo "$simOut"
echo "$simOut" | grep -qx "No errors" && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verification/fpuAddSubChecker.sv
`timescale 1ns/10ps

module fpuAddSubChecker (
  input  logic                clk,
  input  logic                rstN,
  input  fpuBusPkg::axilReq_t bus,
  input  fpuBusPkg::axilRsp_t busRsp,
  input  logic [127:0]        testName,
  output int                  checkCount,
  output int                  errorCount
);

  // Expected RESULT read data, oldest first.
  logic [31:0] expected [$];
  logic [31:0] operands;
  logic [31:0] pendingExp;
  logic [31:0] want;
  logic [3:0]  wrAddr;
  logic [3:0]  rdAddr;

  // FP16 value as a signed count of 2^-24 steps.
  // Every finite FP16 number is exact in this form.
  function automatic longint toScaled(input logic [15:0] h);
    longint mag;
    int     e;
    e = int'(h[14:10]);
    if (e == 0) begin
      mag = longint'(h[9:0]);
    end else begin
      mag = longint'({1'b1, h[9:0]}) << (e - 1);
    end
    return h[15] ? -mag : mag;
  endfunction

  // Exact sum, then round to nearest-even on 11 significant bits.
  // Result is the RESULT register image, zero-extended to 32 bits.
  function automatic logic [31:0] refAddSub(input logic [15:0] x, input logic [15:0] y,
                                            input logic sub);
    logic [15:0] yEff;
    logic [15:0] val;
    logic [3:0]  flags;
    logic        xNaN;
    logic        yNaN;
    logic        xInf;
    logic        yInf;
    longint      s;
    longint      m;
    longint      q;
    longint      rem;
    longint      half;
    int          p;
    int          shift;
    int          expField;
    yEff = {y[15] ^ sub, y[14:0]};
    xNaN = (x[14:10] == 5'h1f) && (x[9:0] != 10'h0);
    yNaN = (y[14:10] == 5'h1f) && (y[9:0] != 10'h0);
    xInf = (x[14:10] == 5'h1f) && (x[9:0] == 10'h0);
    yInf = (y[14:10] == 5'h1f) && (y[9:0] == 10'h0);
    // Flags in order invalid, overflow, underflow, inexact.
    flags = 4'h0;
    val = 16'h0;
    if (xNaN || yNaN) begin
      val = 16'h7E00;
    end else if (xInf && yInf && (x[15] != yEff[15])) begin
      val = 16'h7E00;
      flags[3] = 1'b1;
    end else if (xInf) begin
      val = x;
    end else if (yInf) begin
      val = yEff;
    end else begin
      s = toScaled(x) + toScaled(yEff);
      m = (s < 0) ? -s : s;
      // Exact zero stays +0.
      if (m != 0) begin
        p = 0;
        while ((m >> (p + 1)) != 0) begin
          p++;
        end
        shift = (p > 10) ? p - 10 : 0;
        q = m >> shift;
        rem = m - (q << shift);
        half = (shift > 0) ? (longint'(1) << (shift - 1)) : 0;
        if ((shift > 0) && ((rem > half) || ((rem == half) && q[0]))) begin
          q++;
        end
        // Rounding carried into a new binade.
        if (q == 2048) begin
          q = 1024;
          shift++;
        end
        expField = (q >= 1024) ? shift + 1 : 0;
        flags[0] = (rem != 0);
        flags[1] = (m < 1024) && (rem != 0);
        if (expField > 30) begin
          val = {s < 0, 5'h1f, 10'h0};
          flags[2] = 1'b1;
          flags[0] = 1'b1;
        end else begin
          val = {s < 0, 5'(expField), q[9:0]};
        end
      end
    end
    return {7'h0, 1'b1, flags, val == 16'h0, 1'b0, val[15], 1'b0, val};
  endfunction

  initial begin
    checkCount = 0;
    errorCount = 0;
    operands = 32'h0;
    pendingExp = 32'h0;
    wrAddr = 4'h0;
    rdAddr = 4'h0;
  end

  always @(posedge clk) begin
    if (rstN) begin
      // Operands and commands are taken as the write is accepted.
      if (bus.awvalid && busRsp.awready) begin
        wrAddr = bus.awaddr;
        if (bus.awaddr == fpuBusPkg::ADDR_OPERANDS) begin
          operands = bus.wdata;
        end
        if (bus.awaddr == fpuBusPkg::ADDR_CMD) begin
          pendingExp = refAddSub(operands[15:0], operands[31:16], bus.wdata[0]);
        end
      end
      // Only a CMD write answered with OKAY was queued.
      if (busRsp.bvalid && bus.bready && (wrAddr == fpuBusPkg::ADDR_CMD)
          && (busRsp.bresp == fpuBusPkg::RESP_OKAY)) begin
        expected.push_back(pendingExp);
      end
      if (bus.arvalid && busRsp.arready) begin
        rdAddr = bus.araddr;
      end
      // A RESULT read with valid set retires the oldest command.
      if (busRsp.rvalid && bus.rready && (rdAddr == fpuBusPkg::ADDR_RESULT)
          && busRsp.rdata[24]) begin
        if (expected.size() == 0) begin
          $display("error %0s: valid result read with no accepted command outstanding",
                   testName);
          errorCount++;
        end else begin
          want = expected.pop_front();
          checkCount++;
          if (busRsp.rdata !== want) begin
            $display("mismatch %0s: expected %h, actual %h", testName, want, busRsp.rdata);
            errorCount++;
          end
        end
      end
    end
  end

endmodule

// File: verification/fpuAddSubTb.sv
`timescale 1ns/10ps

module fpuAddSubTb;

  localparam int CMD_DEPTH = 4;
  // Handshake waits and result polls give up after this many tries.
  localparam int MAX_WAIT = 64;

  logic                clk;
  logic                rstN;
  fpuBusPkg::axilReq_t bus;
  fpuBusPkg::axilRsp_t busRsp;
  logic [127:0]        testName;
  int                  chkChecks;
  int                  chkErrors;
  int                  ownChecks;
  int                  ownErrors;
  int                  startChecks;
  int                  startErrors;
  int                  seed;
  int                  r;
  logic [1:0]          resp;
  logic [31:0]         rdata;
  logic [15:0]         opA;
  logic [15:0]         opB;
  event                runAborted;

  fpuAddSubTop #(.CMD_DEPTH(CMD_DEPTH)) dut0 (
    .clk    (clk),
    .rstN   (rstN),
    .bus    (bus),
    .busRsp (busRsp)
  );

  fpuAddSubChecker chk0 (
    .clk        (clk),
    .rstN       (rstN),
    .bus        (bus),
    .busRsp     (busRsp),
    .testName   (testName),
    .checkCount (chkChecks),
    .errorCount (chkErrors)
  );

  // 40 ns period.
  always #20 clk = ~clk;

  // Ends the run after a handshake timeout.
  initial begin
    @(runAborted);
    $display("Errors found");
    $finish;
  end

  task automatic abortRun(input string why);
    $display("timeout: %0s in test %0s", why, testName);
    -> runAborted;
  endtask

  task automatic expectEq(input string what, input logic [31:0] want, input logic [31:0] got);
    ownChecks++;
    if (got !== want) begin
      ownErrors++;
      $display("mismatch %0s %0s: expected %h, actual %h", testName, what, want, got);
    end
  endtask

  // AW and W together, then wait for B.
  task automatic writeReg(input logic [3:0] addr, input logic [31:0] data,
                          output logic [1:0] bresp);
    int waited;
    @(posedge clk);
    bus.awvalid <= 1'b1;
    bus.awaddr <= addr;
    bus.wvalid <= 1'b1;
    bus.wdata <= data;
    bus.bready <= 1'b1;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!(busRsp.awready && busRsp.wready) && (waited < MAX_WAIT));
    if (!(busRsp.awready && busRsp.wready)) begin
      abortRun("write address and data never accepted together");
    end
    bus.awvalid <= 1'b0;
    bus.wvalid <= 1'b0;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!busRsp.bvalid && (waited < MAX_WAIT));
    if (!busRsp.bvalid) begin
      abortRun("write response never arrived");
    end
    bresp = busRsp.bresp;
    bus.bready <= 1'b0;
  endtask

  task automatic readReg(input logic [3:0] addr, output logic [31:0] data,
                         output logic [1:0] rresp);
    int waited;
    @(posedge clk);
    bus.arvalid <= 1'b1;
    bus.araddr <= addr;
    bus.rready <= 1'b1;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!busRsp.arready && (waited < MAX_WAIT));
    if (!busRsp.arready) begin
      abortRun("read address never accepted");
    end
    bus.arvalid <= 1'b0;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!busRsp.rvalid && (waited < MAX_WAIT));
    if (!busRsp.rvalid) begin
      abortRun("read data never arrived");
    end
    data = busRsp.rdata;
    rresp = busRsp.rresp;
    bus.rready <= 1'b0;
  endtask

  // Polls RESULT until bit 24 is set. The checker compares the value.
  task automatic waitResult();
    int polls;
    polls = 0;
    do begin
      readReg(fpuBusPkg::ADDR_RESULT, rdata, resp);
      polls++;
    end while (!rdata[24] && (polls < MAX_WAIT));
    if (!rdata[24]) begin
      abortRun("no valid result after repeated RESULT reads");
    end
  endtask

  task automatic runOp(input logic [15:0] a, input logic [15:0] b, input logic sub);
    writeReg(fpuBusPkg::ADDR_OPERANDS, {b, a}, resp);
    writeReg(fpuBusPkg::ADDR_CMD, {31'h0, sub}, resp);
    expectEq("cmd bresp", {30'h0, fpuBusPkg::RESP_OKAY}, {30'h0, resp});
    waitResult();
  endtask

  // Normal operand, biased exponent 1 to 30.
  function automatic logic [15:0] randomNormal();
    int          v;
    logic [4:0]  e;
    v = $random(seed);
    e = 5'(v[7:0] % 8'd30) + 5'd1;
    return {v[31], e, v[17:8]};
  endfunction

  task automatic startTest(input logic [127:0] name);
    testName = name;
    startChecks = chkChecks + ownChecks;
    startErrors = chkErrors + ownErrors;
  endtask

  task automatic finishTest();
    // One more edge lets the checker retire the last read.
    @(posedge clk);
    $display("test %0s: %0d checks, %0d errors", testName,
             chkChecks + ownChecks - startChecks, chkErrors + ownErrors - startErrors);
  endtask

  initial begin
    seed = 31318;
    clk = 1'b0;
    rstN = 1'b0;
    bus = '0;
    testName = "reset";
    ownChecks = 0;
    ownErrors = 0;
    repeat (3) @(posedge clk);
    rstN <= 1'b1;

    // Nothing issued yet, and a hole in the register map.
    startTest("idle_unmapped");
    readReg(fpuBusPkg::ADDR_RESULT, rdata, resp);
    expectEq("idle valid", 32'h0, {31'h0, rdata[24]});
    writeReg(4'h2, 32'h0000_1234, resp);
    expectEq("write bresp", {30'h0, fpuBusPkg::RESP_SLVERR}, {30'h0, resp});
    readReg(4'hE, rdata, resp);
    expectEq("read rresp", {30'h0, fpuBusPkg::RESP_SLVERR}, {30'h0, resp});
    expectEq("read data", 32'h0, rdata);
    finishTest();

    startTest("random");
    repeat (40) begin
      opA = randomNormal();
      opB = randomNormal();
      r = $random(seed);
      runOp(opA, opB, r[0]);
    end
    finishTest();

    // x - x, then wide exponent gaps.
    startTest("cancel_align");
    runOp(16'h4248, 16'h4248, 1'b1);
    runOp(16'hC248, 16'h4248, 1'b0);
    runOp(16'h7000, 16'h3C00, 1'b0);
    runOp(16'h7000, 16'h0001, 1'b1);
    runOp(16'h6400, 16'h3C00, 1'b0);
    finishTest();

    startTest("ovf_subnormal");
    runOp(16'h7BFF, 16'h7BFF, 1'b0);
    runOp(16'h7BFF, 16'h5000, 1'b0);
    runOp(16'hFBFF, 16'h7BFF, 1'b1);
    runOp(16'h0400, 16'h03FF, 1'b1);
    runOp(16'h0480, 16'h0440, 1'b1);
    runOp(16'h8010, 16'h0200, 1'b0);
    finishTest();

    startTest("nan_inf");
    runOp(16'h7C01, 16'h3C00, 1'b0);
    runOp(16'h3C00, 16'hFE00, 1'b1);
    runOp(16'h7C00, 16'h7C00, 1'b1);
    runOp(16'h7C00, 16'hFC00, 1'b0);
    runOp(16'hFC00, 16'h4000, 1'b0);
    finishTest();

    // The result register and the queue hold CMD_DEPTH + 1 commands.
    startTest("backpressure");
    for (int i = 0; i < CMD_DEPTH + 2; i++) begin
      opA = 16'h4000 | 16'(i << 8);
      writeReg(fpuBusPkg::ADDR_OPERANDS, {16'h3C00, opA}, resp);
      writeReg(fpuBusPkg::ADDR_CMD, 32'h0, resp);
      expectEq("cmd bresp",
               {30'h0, (i <= CMD_DEPTH) ? fpuBusPkg::RESP_OKAY : fpuBusPkg::RESP_SLVERR},
               {30'h0, resp});
    end
    readReg(fpuBusPkg::ADDR_STATUS, rdata, resp);
    expectEq("status count", CMD_DEPTH, rdata);
    for (int i = 0; i <= CMD_DEPTH; i++) begin
      waitResult();
    end
    readReg(fpuBusPkg::ADDR_RESULT, rdata, resp);
    expectEq("drained valid", 32'h0, {31'h0, rdata[24]});
    finishTest();

    $display("totals: %0d checks, %0d errors", chkChecks + ownChecks, chkErrors + ownErrors);
    if ((chkErrors + ownErrors) == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
